// File: sources.f
xpu_pkg.sv
xpu_cfg_regs.sv
rx_header_parse.sv
tsf_timer.sv
nav_timer.sv
tx_rf_track.sv
xpu_top.sv
tb_xpu.sv

// File: run.sh
#!/bin/sh
# compile and run the xpu testbench with verilator
rm -f sim.log
verilator --binary --timing --assert --top-module tb_xpu -f sources.f -o tb_xpu_sim \
    && ./obj_dir/tb_xpu_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
# the log decides the verdict
grep -q "Test failed" sim.log \
    && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation finished without failure"; exit 0; }

// File: tb_xpu.sv
////////////////////////////////////////////////////////////////////////////
// xpu testbench
////////////////////////////////////////////////////////////////////////////

module tb_xpu;
    timeunit 1ns;
    timeprecision 1ps;
    import xpu_pkg::*;

    localparam int unsigned CLK_PER_US = 25;

    // dut ports
    logic       clk;
    logic       reset_i;
    logic       reg_wr_i;
    reg_addr_t  reg_addr_i;
    reg_data_t  reg_wdata_i;
    logic       pkt_header_valid_i;
    logic       pkt_header_valid_strobe_i;
    logic       byte_in_strobe_i;
    logic [7:0] byte_in_i;
    byte_idx_t  byte_count_i;
    logic       fcs_in_strobe_i;
    logic       fcs_ok_i;
    logic       phy_tx_started_i;
    logic       phy_tx_done_i;
    band_t      band_o;
    channel_t   channel_o;
    mac_addr_t  mac_addr_o;
    tsf_t       tsf_runtime_val_o;
    logic       tsf_pulse_1m_o;
    fc_di_t     fc_di_o;
    logic       fc_di_valid_o;
    mac_addr_t  addr1_o;
    logic       addr1_valid_o;
    logic       nav_busy_o;
    logic       tx_bb_is_ongoing_o;
    logic       tx_rf_is_ongoing_o;
    logic       mute_adc_o;

    // expected register contents
    band_t      ref_band;
    channel_t   ref_chan;
    mac_addr_t  ref_mac;
    reg_data_t  ref_tsf_lo;
    reg_data_t  ref_tsf_hi;
    delay_cnt_t ref_delay;
    logic [3:0] ref_ext;
    logic       ref_mute_en;
    logic       ref_mute_val;
    // tsf load pipeline and pulse spacing
    logic        load_p1;
    logic        load_p2;
    int unsigned gap;
    logic        gap_valid;
    tsf_t        tsf_prev;
    // header and nav expectations
    logic       fc_last_d;
    logic       addr1_last_d;
    fc_di_t     exp_fc;
    mac_addr_t  exp_addr1;
    logic       frame_foreign;
    duration_t  ref_nav;
    // expected baseband window and its history
    logic       ref_bb;
    logic [4:0] bb_hist;

    int         errors = 0;
    int         timeouts = 0;
    integer     seed;
    logic [31:0] rnd;
    mac_addr_t  foreign_addr;

    xpu_top #(.CLK_PER_US(CLK_PER_US)) xpu_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // register map and tsf load trigger
    always @(posedge clk) begin
        if (reset_i) begin
            ref_band     <= '0;
            ref_chan     <= '0;
            ref_mac      <= '0;
            ref_tsf_lo   <= '0;
            ref_tsf_hi   <= '0;
            ref_delay    <= '0;
            ref_ext      <= '0;
            ref_mute_en  <= 1'b0;
            ref_mute_val <= 1'b0;
            load_p1      <= 1'b0;
        end else begin
            // load fires only when bit 31 goes from 0 to 1
            load_p1 <= reg_wr_i && (reg_addr_i == REG_TSF_HI) && reg_wdata_i[31] &&
                       !ref_tsf_hi[31];
            if (reg_wr_i) begin
                case (reg_addr_i)
                    REG_TSF_LO: ref_tsf_lo <= reg_wdata_i;
                    REG_TSF_HI: ref_tsf_hi <= reg_wdata_i;
                    REG_BAND_CHAN: begin
                        ref_band <= reg_wdata_i[19:16];
                        ref_chan <= reg_wdata_i[7:0];
                    end
                    REG_MAC_LO: ref_mac[31:0] <= reg_wdata_i;
                    REG_MAC_HI: ref_mac[47:32] <= reg_wdata_i[15:0];
                    REG_TX_DELAY: begin
                        ref_delay <= reg_wdata_i[7:0];
                        ref_ext   <= reg_wdata_i[11:8];
                    end
                    REG_MUTE: begin
                        ref_mute_en  <= reg_wdata_i[0];
                        ref_mute_val <= reg_wdata_i[31];
                    end
                    default: ;
                endcase
            end
        end
    end

    // timing trackers, nav and baseband expectations
    always @(posedge clk) begin
        load_p2      <= load_p1;
        tsf_prev     <= tsf_runtime_val_o;
        fc_last_d    <= byte_in_strobe_i && (byte_count_i == FC_LAST_BYTE);
        addr1_last_d <= byte_in_strobe_i && (byte_count_i == ADDR1_LAST_BYTE);
        if (reset_i) begin
            gap       <= 0;
            gap_valid <= 1'b0;
            ref_nav   <= '0;
            ref_bb    <= 1'b0;
            bb_hist   <= '0;
        end else begin
            // an applied load counts as a fresh microsecond boundary
            if (tsf_pulse_1m_o || load_p2) begin
                gap       <= 1;
                gap_valid <= 1'b1;
            end else begin
                gap <= gap + 1;
            end
            if (fcs_in_strobe_i && fcs_ok_i && frame_foreign && !exp_fc[31]) begin
                if (exp_fc[31:16] > ref_nav) begin
                    ref_nav <= exp_fc[31:16];
                end
            end else if (tsf_pulse_1m_o && (ref_nav != '0)) begin
                ref_nav <= ref_nav - 16'd1;
            end
            if (phy_tx_started_i) begin
                ref_bb <= 1'b1;
            end else if (phy_tx_done_i) begin
                ref_bb <= 1'b0;
            end
            bb_hist <= {bb_hist[3:0], ref_bb};
        end
    end

    function automatic void log_mismatch(string name, logic [63:0] expected,
                                         logic [63:0] actual);
        errors++;
        $display("ERROR %s expected %0h actual %0h at %0t", name, expected, actual, $time);
    endfunction

    a_band: assert property (@(posedge clk) disable iff (reset_i)
        band_o == ref_band && channel_o == ref_chan)
        else log_mismatch("band_channel", 64'($sampled({ref_band, ref_chan})),
                          64'($sampled({band_o, channel_o})));
    a_mac: assert property (@(posedge clk) disable iff (reset_i) mac_addr_o == ref_mac)
        else log_mismatch("mac_addr", 64'($sampled(ref_mac)), 64'($sampled(mac_addr_o)));
    a_tsf_load: assert property (@(posedge clk) disable iff (reset_i)
        load_p2 |-> tsf_runtime_val_o == {1'b0, ref_tsf_hi[30:0], ref_tsf_lo})
        else log_mismatch("tsf_load", $sampled({1'b0, ref_tsf_hi[30:0], ref_tsf_lo}),
                          $sampled(tsf_runtime_val_o));
    a_tsf_gap: assert property (@(posedge clk) disable iff (reset_i)
        tsf_pulse_1m_o && gap_valid |-> gap == CLK_PER_US)
        else log_mismatch("tsf_pulse_gap", 64'(CLK_PER_US), 64'($sampled(gap)));
    a_tsf_tick: assert property (@(posedge clk) disable iff (reset_i)
        tsf_pulse_1m_o |-> tsf_runtime_val_o == tsf_prev + 64'd1)
        else log_mismatch("tsf_tick", $sampled(tsf_prev) + 64'd1,
                          $sampled(tsf_runtime_val_o));
    a_tsf_hold: assert property (@(posedge clk) disable iff (reset_i)
        !tsf_pulse_1m_o && !load_p2 |-> tsf_runtime_val_o == tsf_prev)
        else log_mismatch("tsf_hold", $sampled(tsf_prev), $sampled(tsf_runtime_val_o));
    a_fc_strobe: assert property (@(posedge clk) disable iff (reset_i)
        fc_di_valid_o == fc_last_d)
        else log_mismatch("fc_di_valid", 64'($sampled(fc_last_d)),
                          64'($sampled(fc_di_valid_o)));
    a_fc_data: assert property (@(posedge clk) disable iff (reset_i)
        fc_di_valid_o |-> fc_di_o == exp_fc)
        else log_mismatch("fc_di", 64'($sampled(exp_fc)), 64'($sampled(fc_di_o)));
    a_addr1_strobe: assert property (@(posedge clk) disable iff (reset_i)
        addr1_valid_o == addr1_last_d)
        else log_mismatch("addr1_valid", 64'($sampled(addr1_last_d)),
                          64'($sampled(addr1_valid_o)));
    a_addr1_data: assert property (@(posedge clk) disable iff (reset_i)
        addr1_valid_o |-> addr1_o == exp_addr1)
        else log_mismatch("addr1", 64'($sampled(exp_addr1)), 64'($sampled(addr1_o)));
    a_nav: assert property (@(posedge clk) disable iff (reset_i)
        nav_busy_o == (ref_nav != '0))
        else log_mismatch("nav_busy", 64'($sampled(ref_nav != '0)),
                          64'($sampled(nav_busy_o)));
    a_bb: assert property (@(posedge clk) disable iff (reset_i)
        tx_bb_is_ongoing_o == ref_bb)
        else log_mismatch("tx_bb", 64'($sampled(ref_bb)),
                          64'($sampled(tx_bb_is_ongoing_o)));
    // rf on 3 cycles after bb, off 3 + 2 cycles after bb
    a_rf: assert property (@(posedge clk) disable iff (reset_i)
        (ref_delay == 8'd3 && ref_ext == 4'd2) |->
        tx_rf_is_ongoing_o == (bb_hist[2] || bb_hist[4]))
        else log_mismatch("tx_rf", 64'($sampled(bb_hist[2] || bb_hist[4])),
                          64'($sampled(tx_rf_is_ongoing_o)));
    a_mute: assert property (@(posedge clk) disable iff (reset_i)
        mute_adc_o == (ref_mute_en ? ref_mute_val : tx_rf_is_ongoing_o))
        else log_mismatch("mute_adc",
                          64'($sampled(ref_mute_en ? ref_mute_val : tx_rf_is_ongoing_o)),
                          64'($sampled(mute_adc_o)));

    task automatic write_reg(reg_addr_t addr, reg_data_t data);
        @(negedge clk);
        reg_wr_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(negedge clk);
        reg_wr_i    = 1'b0;
    endtask

    task automatic wait_pulses(int count, int limit);
        int seen;
        int n;
        seen = 0;
        n = 0;
        while (seen < count && n < limit) begin
            @(negedge clk);
            n++;
            if (tsf_pulse_1m_o) begin
                seen++;
            end
        end
        if (seen < count) begin
            timeouts++;
            $display("timeout: only %0d of %0d microsecond pulses seen", seen, count);
        end
    endtask

    task automatic wait_nav_clear(int limit);
        int n;
        n = 0;
        while (nav_busy_o && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (nav_busy_o) begin
            timeouts++;
            $display("timeout: NAV still busy after %0d cycles", limit);
        end
    endtask

    task automatic wait_rf(logic level, int limit);
        int n;
        n = 0;
        while (tx_rf_is_ongoing_o != level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (tx_rf_is_ongoing_o != level) begin
            timeouts++;
            $display("timeout: rf window never went to %0b", level);
        end
    endtask

    // header strobe, bytes 0..9, a gap, then the fcs verdict
    task automatic send_frame(fc_di_t fc_word, mac_addr_t addr1, logic fcs_good);
        int i;
        exp_fc        = fc_word;
        exp_addr1     = addr1;
        frame_foreign = (addr1 != ref_mac);
        @(negedge clk);
        pkt_header_valid_strobe_i = 1'b1;
        pkt_header_valid_i        = 1'b1;
        @(negedge clk);
        pkt_header_valid_strobe_i = 1'b0;
        pkt_header_valid_i        = 1'b0;
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            byte_in_strobe_i = 1'b1;
            byte_count_i     = byte_idx_t'(i);
            if (i < 4) begin
                byte_in_i = fc_word[8*i +: 8];
            end else begin
                byte_in_i = addr1[8*(i-4) +: 8];
            end
        end
        @(negedge clk);
        byte_in_strobe_i = 1'b0;
        repeat (4) @(negedge clk);
        fcs_in_strobe_i = 1'b1;
        fcs_ok_i        = fcs_good;
        @(negedge clk);
        fcs_in_strobe_i = 1'b0;
        fcs_ok_i        = 1'b0;
    endtask

    task automatic tx_burst(int len);
        @(negedge clk);
        phy_tx_started_i = 1'b1;
        @(negedge clk);
        phy_tx_started_i = 1'b0;
        wait_rf(1'b1, 50);
        repeat (len) @(negedge clk);
        phy_tx_done_i = 1'b1;
        @(negedge clk);
        phy_tx_done_i = 1'b0;
        wait_rf(1'b0, 50);
    endtask

    initial begin
        seed                      = 32'h7ba7472e;
        reset_i                   = 1'b1;
        reg_wr_i                  = 1'b0;
        reg_addr_i                = '0;
        reg_wdata_i               = '0;
        pkt_header_valid_i        = 1'b0;
        pkt_header_valid_strobe_i = 1'b0;
        byte_in_strobe_i          = 1'b0;
        byte_in_i                 = '0;
        byte_count_i              = '0;
        fcs_in_strobe_i           = 1'b0;
        fcs_ok_i                  = 1'b0;
        phy_tx_started_i          = 1'b0;
        phy_tx_done_i             = 1'b0;
        exp_fc                    = '0;
        exp_addr1                 = '0;
        frame_foreign             = 1'b0;
        repeat (8) @(negedge clk);
        reset_i = 1'b0;

        // 2.4GHz band, channel 6, own mac
        write_reg(REG_BAND_CHAN, 32'h0001_0006);
        write_reg(REG_MAC_LO, 32'h5544_3322);
        write_reg(REG_MAC_HI, 32'h0000_0a11);

        // tsf load, then a few microseconds of counting
        write_reg(REG_TSF_LO, 32'h89ab_cdef);
        write_reg(REG_TSF_HI, 32'h8000_1234);
        wait_pulses(3, 100);

        rnd = $random(seed);
        foreign_addr[31:0] = rnd;
        rnd = $random(seed);
        foreign_addr[47:32] = rnd[15:0];

        // data frame to another station with a 5 us duration
        send_frame({16'd5, 16'h0208}, foreign_addr, 1'b1);
        wait_nav_clear(300);
        // same frame to us, then a bad fcs, then an aid style duration
        send_frame({16'd5, 16'h0208}, ref_mac, 1'b1);
        send_frame({16'd7, 16'h0208}, foreign_addr, 1'b0);
        send_frame({16'h8005, 16'h00a4}, foreign_addr, 1'b1);
        wait_pulses(2, 100);

        // tx windows with delay 3 and tail 2
        write_reg(REG_TX_DELAY, 32'h0000_0203);
        tx_burst(20);
        // override forces mute on, then off
        write_reg(REG_MUTE, 32'h8000_0001);
        tx_burst(10);
        write_reg(REG_MUTE, 32'h0000_0001);
        tx_burst(10);
        write_reg(REG_MUTE, 32'h0000_0000);
        repeat (10) @(negedge clk);

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: xpu_top.sv
////////////////////////////////////////////////////////////////////////////
// xpu low mac top
////////////////////////////////////////////////////////////////////////////

module xpu_top #(
    parameter int unsigned CLK_PER_US = 100
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               reg_wr_i,
    input  xpu_pkg::reg_addr_t reg_addr_i,
    input  xpu_pkg::reg_data_t reg_wdata_i,
    input  logic               pkt_header_valid_i,
    input  logic               pkt_header_valid_strobe_i,
    input  logic               byte_in_strobe_i,
    input  logic [7:0]         byte_in_i,
    input  xpu_pkg::byte_idx_t byte_count_i,
    input  logic               fcs_in_strobe_i,
    input  logic               fcs_ok_i,
    input  logic               phy_tx_started_i,
    input  logic               phy_tx_done_i,
    output xpu_pkg::band_t     band_o,
    output xpu_pkg::channel_t  channel_o,
    output xpu_pkg::mac_addr_t mac_addr_o,
    output xpu_pkg::tsf_t      tsf_runtime_val_o,
    output logic               tsf_pulse_1m_o,
    output xpu_pkg::fc_di_t    fc_di_o,
    output logic               fc_di_valid_o,
    output xpu_pkg::mac_addr_t addr1_o,
    output logic               addr1_valid_o,
    output logic               nav_busy_o,
    output logic               tx_bb_is_ongoing_o,
    output logic               tx_rf_is_ongoing_o,
    output logic               mute_adc_o
);
    import xpu_pkg::*;

    delay_cnt_t bb_rf_delay;
    logic [3:0] rf_end_ext;
    logic       mute_ovr_en;
    logic       mute_ovr_val;
    logic       tsf_load;
    tsf_t       tsf_load_val;
    logic       addr1_is_self;
    // good header and good fcs strobes
    logic       sig_valid;
    logic       fcs_valid;

    assign sig_valid = pkt_header_valid_strobe_i & pkt_header_valid_i;
    assign fcs_valid = fcs_in_strobe_i & fcs_ok_i;

    xpu_cfg_regs xpu_cfg_regs_inst (
        .clk(clk), .reset_i(reset_i),
        .reg_wr_i(reg_wr_i), .reg_addr_i(reg_addr_i), .reg_wdata_i(reg_wdata_i),
        .band_o(band_o), .channel_o(channel_o), .mac_addr_o(mac_addr_o),
        .bb_rf_delay_o(bb_rf_delay), .rf_end_ext_o(rf_end_ext),
        .mute_ovr_en_o(mute_ovr_en), .mute_ovr_val_o(mute_ovr_val),
        .tsf_load_o(tsf_load), .tsf_load_val_o(tsf_load_val)
    );

    rx_header_parse rx_header_parse_inst (
        .clk(clk), .reset_i(reset_i), .sig_valid_i(sig_valid),
        .byte_in_strobe_i(byte_in_strobe_i), .byte_in_i(byte_in_i),
        .byte_count_i(byte_count_i), .mac_addr_i(mac_addr_o),
        .fc_di_o(fc_di_o), .fc_di_valid_o(fc_di_valid_o),
        .addr1_o(addr1_o), .addr1_valid_o(addr1_valid_o),
        .addr1_is_self_o(addr1_is_self)
    );

    tsf_timer #(.CLK_PER_US(CLK_PER_US)) tsf_timer_inst (
        .clk(clk), .reset_i(reset_i),
        .tsf_load_i(tsf_load), .tsf_load_val_i(tsf_load_val),
        .tsf_runtime_val_o(tsf_runtime_val_o), .tsf_pulse_1m_o(tsf_pulse_1m_o)
    );

    nav_timer nav_timer_inst (
        .clk(clk), .reset_i(reset_i), .sig_valid_i(sig_valid),
        .fc_di_i(fc_di_o), .addr1_valid_i(addr1_valid_o),
        .addr1_is_self_i(addr1_is_self), .fcs_valid_i(fcs_valid),
        .tsf_pulse_1m_i(tsf_pulse_1m_o), .nav_busy_o(nav_busy_o)
    );

    tx_rf_track tx_rf_track_inst (
        .clk(clk), .reset_i(reset_i),
        .phy_tx_started_i(phy_tx_started_i), .phy_tx_done_i(phy_tx_done_i),
        .bb_rf_delay_i(bb_rf_delay), .rf_end_ext_i(rf_end_ext),
        .mute_ovr_en_i(mute_ovr_en), .mute_ovr_val_i(mute_ovr_val),
        .tx_bb_is_ongoing_o(tx_bb_is_ongoing_o),
        .tx_rf_is_ongoing_o(tx_rf_is_ongoing_o), .mute_adc_o(mute_adc_o)
    );

endmodule

// File: tx_rf_track.sv
////////////////////////////////////////////////////////////////////////////
// tx baseband and rf window tracking
////////////////////////////////////////////////////////////////////////////

module tx_rf_track (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                phy_tx_started_i,
    input  logic                phy_tx_done_i,
    input  xpu_pkg::delay_cnt_t bb_rf_delay_i,
    input  logic [3:0]          rf_end_ext_i,
    input  logic                mute_ovr_en_i,
    input  logic                mute_ovr_val_i,
    output logic                tx_bb_is_ongoing_o,
    output logic                tx_rf_is_ongoing_o,
    output logic                mute_adc_o
);

    typedef enum logic [1:0] {IDLE, RF_WAIT, ON_AIR, RF_TAIL} tx_state_t;

    tx_state_t  state_q;
    // tail can reach 15 + 255 cycles
    logic [8:0] cnt_q;
    logic [8:0] tail_len;

    assign tail_len = {5'd0, rf_end_ext_i} + {1'b0, bb_rf_delay_i};

    // baseband window follows the phy strobes by one cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            tx_bb_is_ongoing_o <= 1'b0;
        end else if (phy_tx_started_i) begin
            tx_bb_is_ongoing_o <= 1'b1;
        end else if (phy_tx_done_i) begin
            tx_bb_is_ongoing_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: if (phy_tx_started_i) begin
                    state_q <= (bb_rf_delay_i == '0) ? ON_AIR : RF_WAIT;
                    cnt_q   <= {1'b0, bb_rf_delay_i} - 9'd1;
                end
                RF_WAIT: if (phy_tx_done_i) begin
                    // very short tx goes straight to the tail
                    state_q <= RF_TAIL;
                    cnt_q   <= tail_len;
                end else if (cnt_q == '0) begin
                    state_q <= ON_AIR;
                end else begin
                    cnt_q <= cnt_q - 9'd1;
                end
                ON_AIR: if (phy_tx_done_i) begin
                    state_q <= (tail_len == '0) ? IDLE : RF_TAIL;
                    cnt_q   <= tail_len - 9'd1;
                end
                RF_TAIL: if (phy_tx_started_i) begin
                    // back to back tx keeps rf on
                    state_q <= ON_AIR;
                end else if (cnt_q == '0) begin
                    state_q <= IDLE;
                end else begin
                    cnt_q <= cnt_q - 9'd1;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign tx_rf_is_ongoing_o = (state_q == ON_AIR) || (state_q == RF_TAIL);

    // own rx muted while on air unless software overrides
    assign mute_adc_o = mute_ovr_en_i ? mute_ovr_val_i : tx_rf_is_ongoing_o;

endmodule

// File: nav_timer.sv
////////////////////////////////////////////////////////////////////////////
// nav countdown
////////////////////////////////////////////////////////////////////////////

module nav_timer (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            sig_valid_i,
    input  xpu_pkg::fc_di_t fc_di_i,
    input  logic            addr1_valid_i,
    input  logic            addr1_is_self_i,
    input  logic            fcs_valid_i,
    input  logic            tsf_pulse_1m_i,
    output logic            nav_busy_o
);
    import xpu_pkg::*;

    duration_t duration;
    duration_t nav_q;
    // addr1 seen for this frame and not ours
    logic      foreign_q;
    logic      nav_load;

    assign duration = fc_di_i[31:16];

    // bit 15 set means an aid or reserved value, not a duration
    assign nav_load = fcs_valid_i && foreign_q && !duration[15];

    always_ff @(posedge clk) begin
        if (reset_i || sig_valid_i || fcs_valid_i) begin
            foreign_q <= 1'b0;
        end else if (addr1_valid_i) begin
            foreign_q <= !addr1_is_self_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            nav_q <= '0;
        end else if (nav_load) begin
            // nav only ever extends
            if (duration > nav_q) begin
                nav_q <= duration;
            end
        end else if (tsf_pulse_1m_i && (nav_q != '0)) begin
            nav_q <= nav_q - 16'd1;
        end
    end

    assign nav_busy_o = (nav_q != '0);

endmodule

// File: tsf_timer.sv
////////////////////////////////////////////////////////////////////////////
// tsf timer
////////////////////////////////////////////////////////////////////////////

module tsf_timer #(
    parameter int unsigned CLK_PER_US = 100
) (
    input  logic          clk,
    input  logic          reset_i,
    input  logic          tsf_load_i,
    input  xpu_pkg::tsf_t tsf_load_val_i,
    output xpu_pkg::tsf_t tsf_runtime_val_o,
    output logic          tsf_pulse_1m_o
);

    // prescaler wide enough for CLK_PER_US - 1
    localparam int unsigned PRESC_W = $clog2(CLK_PER_US + 1);
    localparam logic [PRESC_W-1:0] PRESC_TOP = PRESC_W'(CLK_PER_US - 1);

    logic [PRESC_W-1:0] presc_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            presc_q           <= '0;
            tsf_runtime_val_o <= '0;
            tsf_pulse_1m_o    <= 1'b0;
        end else if (tsf_load_i) begin
            // load restarts the microsecond
            presc_q           <= '0;
            tsf_runtime_val_o <= tsf_load_val_i;
            tsf_pulse_1m_o    <= 1'b0;
        end else if (presc_q == PRESC_TOP) begin
            // pulse and tick together on the wrap
            presc_q           <= '0;
            tsf_runtime_val_o <= tsf_runtime_val_o + 64'd1;
            tsf_pulse_1m_o    <= 1'b1;
        end else begin
            presc_q        <= presc_q + PRESC_W'(1);
            tsf_pulse_1m_o <= 1'b0;
        end
    end

endmodule

// File: rx_header_parse.sv
////////////////////////////////////////////////////////////////////////////
// rx mac header parser
////////////////////////////////////////////////////////////////////////////

module rx_header_parse (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               sig_valid_i,
    input  logic               byte_in_strobe_i,
    input  logic [7:0]         byte_in_i,
    input  xpu_pkg::byte_idx_t byte_count_i,
    input  xpu_pkg::mac_addr_t mac_addr_i,
    output xpu_pkg::fc_di_t    fc_di_o,
    output logic               fc_di_valid_o,
    output xpu_pkg::mac_addr_t addr1_o,
    output logic               addr1_valid_o,
    output logic               addr1_is_self_o
);
    import xpu_pkg::*;

    // byte position relative to the start of each field
    byte_idx_t fc_off;
    byte_idx_t addr1_off;
    logic      in_fc;
    logic      in_addr1;

    // offsets wrap below the first byte, so one compare covers the range
    assign fc_off    = byte_count_i - FC_FIRST_BYTE;
    assign addr1_off = byte_count_i - ADDR1_FIRST_BYTE;
    assign in_fc     = byte_in_strobe_i && (fc_off <= (FC_LAST_BYTE - FC_FIRST_BYTE));
    assign in_addr1  = byte_in_strobe_i &&
                       (addr1_off <= (ADDR1_LAST_BYTE - ADDR1_FIRST_BYTE));

    always_ff @(posedge clk) begin
        // a new header starts a clean capture
        if (reset_i || sig_valid_i) begin
            fc_di_o       <= '0;
            fc_di_valid_o <= 1'b0;
            addr1_o       <= '0;
            addr1_valid_o <= 1'b0;
        end else begin
            // valids pulse one cycle after the last byte of a field
            fc_di_valid_o <= byte_in_strobe_i && (byte_count_i == FC_LAST_BYTE);
            addr1_valid_o <= byte_in_strobe_i && (byte_count_i == ADDR1_LAST_BYTE);
            // little endian so the first byte lands in bits 7:0
            if (in_fc) begin
                fc_di_o[{fc_off[1:0], 3'b000} +: 8] <= byte_in_i;
            end
            if (in_addr1) begin
                addr1_o[{addr1_off[2:0], 3'b000} +: 8] <= byte_in_i;
            end
        end
    end

    // own address match holds meaning while addr1_valid_o is high
    assign addr1_is_self_o = (addr1_o == mac_addr_i);

endmodule

// File: xpu_cfg_regs.sv
////////////////////////////////////////////////////////////////////////////
// xpu configuration registers
////////////////////////////////////////////////////////////////////////////

module xpu_cfg_regs (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                reg_wr_i,
    input  xpu_pkg::reg_addr_t  reg_addr_i,
    input  xpu_pkg::reg_data_t  reg_wdata_i,
    output xpu_pkg::band_t      band_o,
    output xpu_pkg::channel_t   channel_o,
    output xpu_pkg::mac_addr_t  mac_addr_o,
    output xpu_pkg::delay_cnt_t bb_rf_delay_o,
    output logic [3:0]          rf_end_ext_o,
    output logic                mute_ovr_en_o,
    output logic                mute_ovr_val_o,
    output logic                tsf_load_o,
    output xpu_pkg::tsf_t       tsf_load_val_o
);
    import xpu_pkg::*;

    // stored register fields
    reg_data_t   tsf_lo_q;
    reg_data_t   tsf_hi_q;
    band_t       band_q;
    channel_t    channel_q;
    reg_data_t   mac_lo_q;
    logic [15:0] mac_hi_q;
    delay_cnt_t  bb_rf_delay_q;
    logic [3:0]  rf_end_ext_q;
    logic        mute_en_q;
    logic        mute_val_q;
    logic        tsf_load_q;
    logic        tsf_hi_wr;

    assign tsf_hi_wr = reg_wr_i && (reg_addr_i == REG_TSF_HI);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tsf_lo_q      <= '0;
            tsf_hi_q      <= '0;
            band_q        <= '0;
            channel_q     <= '0;
            mac_lo_q      <= '0;
            mac_hi_q      <= '0;
            bb_rf_delay_q <= '0;
            rf_end_ext_q  <= '0;
            mute_en_q     <= 1'b0;
            mute_val_q    <= 1'b0;
            tsf_load_q    <= 1'b0;
        end else begin
            // load only on a 0 -> 1 change of the trigger bit
            tsf_load_q <= tsf_hi_wr && reg_wdata_i[31] && !tsf_hi_q[31];
            if (reg_wr_i) begin
                case (reg_addr_i)
                    REG_TSF_LO: tsf_lo_q <= reg_wdata_i;
                    REG_TSF_HI: tsf_hi_q <= reg_wdata_i;
                    REG_BAND_CHAN: begin
                        band_q    <= reg_wdata_i[19:16];
                        channel_q <= reg_wdata_i[7:0];
                    end
                    REG_MAC_LO: mac_lo_q <= reg_wdata_i;
                    REG_MAC_HI: mac_hi_q <= reg_wdata_i[15:0];
                    REG_TX_DELAY: begin
                        bb_rf_delay_q <= reg_wdata_i[7:0];
                        rf_end_ext_q  <= reg_wdata_i[11:8];
                    end
                    REG_MUTE: begin
                        mute_en_q  <= reg_wdata_i[0];
                        mute_val_q <= reg_wdata_i[31];
                    end
                    // unmapped addresses are ignored
                    default: ;
                endcase
            end
        end
    end

    // field decode
    assign band_o         = band_q;
    assign channel_o      = channel_q;
    assign mac_addr_o     = {mac_hi_q, mac_lo_q};
    assign bb_rf_delay_o  = bb_rf_delay_q;
    assign rf_end_ext_o   = rf_end_ext_q;
    assign mute_ovr_en_o  = mute_en_q;
    assign mute_ovr_val_o = mute_val_q;
    assign tsf_load_o     = tsf_load_q;
    // trigger bit is not part of the value
    assign tsf_load_val_o = {1'b0, tsf_hi_q[30:0], tsf_lo_q};

endmodule

// File: xpu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// xpu shared types and constants
////////////////////////////////////////////////////////////////////////////

package xpu_pkg;

    // widths with a meaning of their own
    typedef logic [3:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;
    // tsf in microseconds, 802.11 timer width
    typedef logic [63:0] tsf_t;
    typedef logic [47:0] mac_addr_t;
    // frame control in 15:0, duration in 31:16
    typedef logic [31:0] fc_di_t;
    typedef logic [15:0] duration_t;
    typedef logic [15:0] byte_idx_t;
    // 1 means 2.4GHz
    typedef logic [3:0]  band_t;
    typedef logic [7:0]  channel_t;
    typedef logic [7:0]  delay_cnt_t;

    // register map
    localparam reg_addr_t REG_TSF_LO    = 4'd0;
    // bit 31 load trigger, 30:0 tsf high bits
    localparam reg_addr_t REG_TSF_HI    = 4'd1;
    localparam reg_addr_t REG_BAND_CHAN = 4'd2;
    localparam reg_addr_t REG_MAC_LO    = 4'd3;
    localparam reg_addr_t REG_MAC_HI    = 4'd4;
    localparam reg_addr_t REG_TX_DELAY  = 4'd5;
    localparam reg_addr_t REG_MUTE      = 4'd6;

    // mac header byte positions in the rx stream
    localparam byte_idx_t FC_FIRST_BYTE    = 16'd0;
    localparam byte_idx_t FC_LAST_BYTE     = 16'd3;
    localparam byte_idx_t ADDR1_FIRST_BYTE = 16'd4;
    localparam byte_idx_t ADDR1_LAST_BYTE  = 16'd9;

endpackage
